//--- rp_macros.svh
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// sample and pin widths
`define RP_SMP_W      14
`define RP_ADC_PIN_W  16

// calibration gain, 1.0 is 2^14
`define RP_MUL_W      16
`define RP_MUL_FRAC   14
`define RP_MUL_ONE    16384

// channel counts, fixed by the pins
`define RP_ADC_CHN    2
`define RP_DAC_CHN    2
`define RP_PDM_CHN    4
`define RP_PDM_W      8

// register bus
`define RP_ADDR_W     8
`define RP_DATA_W     32

// register map
`define RP_REG_CTRL     8'h00
`define RP_REG_ADC0_MUL 8'h10
`define RP_REG_ADC0_SUM 8'h14
`define RP_REG_ADC1_MUL 8'h18
`define RP_REG_ADC1_SUM 8'h1C
`define RP_REG_DAC0_MUL 8'h20
`define RP_REG_DAC0_SUM 8'h24
`define RP_REG_DAC1_MUL 8'h28
`define RP_REG_DAC1_SUM 8'h2C
`define RP_REG_DAC0_LVL 8'h30
`define RP_REG_DAC1_LVL 8'h34
`define RP_REG_PDM0     8'h40
`define RP_REG_PDM1     8'h44
`define RP_REG_PDM2     8'h48
`define RP_REG_PDM3     8'h4C

`endif

//--- rp_pkg.sv
`default_nettype none

`include "rp_macros.svh"

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample and calibration types
  //////////////////////////////////////////////////////////////////////

  // two's complement sample, same on ADC and DAC side
  typedef logic signed [`RP_SMP_W-1:0] smp_t;

  // gain and offset
  typedef logic signed [`RP_MUL_W-1:0] cal_mul_t;
  typedef logic signed [`RP_SMP_W-1:0] cal_sum_t;

  typedef struct packed {
    cal_mul_t mul;
    cal_sum_t sum;
  } cal_t;

  // ch0 sits in the low bits
  typedef struct packed {
    smp_t ch1;
    smp_t ch0;
  } smp_pair_t;

  // one unsigned level per PDM output
  typedef logic [`RP_PDM_CHN-1:0][`RP_PDM_W-1:0] pdm_lvl_t;

  //////////////////////////////////////////////////////////////////////
  // register bus
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  wen;
    logic                  ren;
    logic [`RP_ADDR_W-1:0] addr;
    logic [`RP_DATA_W-1:0] wdata;
  } sys_req_t;

  typedef struct packed {
    logic [`RP_DATA_W-1:0] rdata;
    logic                  ack;
  } sys_rsp_t;

  // register addresses
  typedef enum logic [`RP_ADDR_W-1:0] {
    REG_CTRL     = `RP_REG_CTRL,
    REG_ADC0_MUL = `RP_REG_ADC0_MUL,
    REG_ADC0_SUM = `RP_REG_ADC0_SUM,
    REG_ADC1_MUL = `RP_REG_ADC1_MUL,
    REG_ADC1_SUM = `RP_REG_ADC1_SUM,
    REG_DAC0_MUL = `RP_REG_DAC0_MUL,
    REG_DAC0_SUM = `RP_REG_DAC0_SUM,
    REG_DAC1_MUL = `RP_REG_DAC1_MUL,
    REG_DAC1_SUM = `RP_REG_DAC1_SUM,
    REG_DAC0_LVL = `RP_REG_DAC0_LVL,
    REG_DAC1_LVL = `RP_REG_DAC1_LVL,
    REG_PDM0     = `RP_REG_PDM0,
    REG_PDM1     = `RP_REG_PDM1,
    REG_PDM2     = `RP_REG_PDM2,
    REG_PDM3     = `RP_REG_PDM3
  } rp_reg_e;

endpackage

`default_nettype wire

//--- rp_linear.sv
`timescale 1ns/1ps
`default_nettype none

`include "rp_macros.svh"

module rp_linear (
  input  logic         adc_clk,
  input  logic         top_rst,
  input  rp_pkg::smp_t smp_i,
  input  rp_pkg::cal_t cal_i,
  output rp_pkg::smp_t smp_o
);

  // full product width, 14 x 16
  localparam int PRD_W   = `RP_SMP_W + `RP_MUL_W;
  // output range
  localparam int SMP_MAX = 2**(`RP_SMP_W-1) - 1;
  localparam int SMP_MIN = -(2**(`RP_SMP_W-1));

  logic signed [PRD_W-1:0] prd_q;
  logic signed [PRD_W-1:0] sum_c;

  //////////////////////////////////////////////////////////////////////
  // stage 1, gain
  //////////////////////////////////////////////////////////////////////

  // both operands sign extended to product width
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prd_q <= '0;
    end else begin
      prd_q <= PRD_W'(smp_i) * PRD_W'(cal_i.mul);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, offset and saturation
  //////////////////////////////////////////////////////////////////////

  // drop gain fraction, then add offset
  // shifted product fits 16 bits, sum fits 17, no overflow here
  assign sum_c = (prd_q >>> `RP_MUL_FRAC) + PRD_W'(cal_i.sum);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else if (sum_c > SMP_MAX) begin
      // clip high
      smp_o <= rp_pkg::smp_t'(SMP_MAX);
    end else if (sum_c < SMP_MIN) begin
      // clip low
      smp_o <= rp_pkg::smp_t'(SMP_MIN);
    end else begin
      smp_o <= rp_pkg::smp_t'(sum_c);
    end
  end

endmodule

`default_nettype wire

//--- rp_adc_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "rp_macros.svh"

module rp_adc_front (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // raw ADC pins, low 2 bits unused
  input  logic [`RP_ADC_PIN_W-1:0] adc_pin_i,
  // calibrated DAC sample for loopback
  input  rp_pkg::smp_t             loop_smp_i,
  input  logic                     digital_loop_i,
  input  rp_pkg::cal_t             cal_i,
  output rp_pkg::smp_t             smp_o
);

  rp_pkg::smp_t pin_q;
  rp_pkg::smp_t lin_in;

  // pin register
  // keep sign, invert magnitude bits, drop the 2 LSBs
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      pin_q <= '0;
    end else begin
      pin_q <= {adc_pin_i[`RP_ADC_PIN_W-1],
                ~adc_pin_i[`RP_ADC_PIN_W-2:`RP_ADC_PIN_W-`RP_SMP_W]};
    end
  end

  // loopback mux, DAC side replaces pins
  assign lin_in = digital_loop_i ? loop_smp_i : pin_q;

  // gain and offset, 2 cycles
  rp_linear rp_linear_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (lin_in),
    .cal_i   (cal_i),
    .smp_o   (smp_o)
  );

endmodule

`default_nettype wire

//--- rp_dac_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "rp_macros.svh"

module rp_dac_out (
  input  logic         adc_clk,
  input  logic         top_rst,
  // DAC level from register file
  input  rp_pkg::smp_t lvl_i,
  input  rp_pkg::cal_t cal_i,
  // calibrated sample, also goes to loopback
  output rp_pkg::smp_t cal_smp_o,
  // DAC pin word
  output rp_pkg::smp_t dac_o
);

  // converted form of a zero sample
  localparam rp_pkg::smp_t DAC_ZERO = {1'b0, {(`RP_SMP_W-1){1'b1}}};

  // gain and offset, 2 cycles
  rp_linear rp_linear_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (lvl_i),
    .cal_i   (cal_i),
    .smp_o   (cal_smp_o)
  );

  //////////////////////////////////////////////////////////////////////
  // DAC format
  //////////////////////////////////////////////////////////////////////

  // offset binary with negative slope
  // keep sign bit, invert the rest
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_o <= DAC_ZERO;
    end else begin
      dac_o <= {cal_smp_o[`RP_SMP_W-1], ~cal_smp_o[`RP_SMP_W-2:0]};
    end
  end

endmodule

`default_nettype wire

//--- rp_pdm.sv
`timescale 1ns/1ps
`default_nettype none

`include "rp_macros.svh"

module rp_pdm (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  input  rp_pkg::pdm_lvl_t       lvl_i,
  output logic [`RP_PDM_CHN-1:0] pdm_o
);

  // one accumulator per output
  logic [`RP_PDM_CHN-1:0][`RP_PDM_W-1:0] acc_q;

  // first order modulator
  // carry out of acc + lvl is the pulse
  // 256 cycles give exactly lvl carries
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        // level used directly, no shadow register
        {pdm_o[i], acc_q[i]} <= (`RP_PDM_W+1)'(acc_q[i]) + (`RP_PDM_W+1)'(lvl_i[i]);
      end
    end
  end

endmodule

`default_nettype wire

//--- rp_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rp_macros.svh"

module rp_regs (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // register bus
  input  rp_pkg::sys_req_t                    sys_req_i,
  output rp_pkg::sys_rsp_t                    sys_rsp_o,
  // settings
  output logic                                digital_loop_o,
  output rp_pkg::cal_t [`RP_ADC_CHN-1:0]      adc_cal_o,
  output rp_pkg::cal_t [`RP_DAC_CHN-1:0]      dac_cal_o,
  output rp_pkg::smp_t [`RP_DAC_CHN-1:0]      dac_lvl_o,
  output rp_pkg::pdm_lvl_t                    pdm_lvl_o
);

  rp_pkg::rp_reg_e       reg_addr;
  rp_pkg::cal_mul_t      wr_mul;
  rp_pkg::cal_sum_t      wr_sum;
  rp_pkg::smp_t          wr_lvl;
  logic [`RP_PDM_W-1:0]  wr_pdm;
  logic [`RP_DATA_W-1:0] rd_data;
  logic [`RP_DATA_W-1:0] rdata_q;
  logic                  ack_q;

  // address decode and write field slices
  assign reg_addr = rp_pkg::rp_reg_e'(sys_req_i.addr);
  assign wr_mul   = rp_pkg::cal_mul_t'(sys_req_i.wdata[`RP_MUL_W-1:0]);
  assign wr_sum   = rp_pkg::cal_sum_t'(sys_req_i.wdata[`RP_SMP_W-1:0]);
  assign wr_lvl   = rp_pkg::smp_t'(sys_req_i.wdata[`RP_SMP_W-1:0]);
  assign wr_pdm   = sys_req_i.wdata[`RP_PDM_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      digital_loop_o <= 1'b0;
      // unity gain, zero offset
      for (int i = 0; i < `RP_ADC_CHN; i++) begin
        adc_cal_o[i].mul <= rp_pkg::cal_mul_t'(`RP_MUL_ONE);
        adc_cal_o[i].sum <= '0;
      end
      for (int i = 0; i < `RP_DAC_CHN; i++) begin
        dac_cal_o[i].mul <= rp_pkg::cal_mul_t'(`RP_MUL_ONE);
        dac_cal_o[i].sum <= '0;
        dac_lvl_o[i]     <= '0;
      end
      pdm_lvl_o <= '0;
    end else if (sys_req_i.wen) begin
      case (reg_addr)
        rp_pkg::REG_CTRL:     digital_loop_o   <= sys_req_i.wdata[0];
        rp_pkg::REG_ADC0_MUL: adc_cal_o[0].mul <= wr_mul;
        rp_pkg::REG_ADC0_SUM: adc_cal_o[0].sum <= wr_sum;
        rp_pkg::REG_ADC1_MUL: adc_cal_o[1].mul <= wr_mul;
        rp_pkg::REG_ADC1_SUM: adc_cal_o[1].sum <= wr_sum;
        rp_pkg::REG_DAC0_MUL: dac_cal_o[0].mul <= wr_mul;
        rp_pkg::REG_DAC0_SUM: dac_cal_o[0].sum <= wr_sum;
        rp_pkg::REG_DAC1_MUL: dac_cal_o[1].mul <= wr_mul;
        rp_pkg::REG_DAC1_SUM: dac_cal_o[1].sum <= wr_sum;
        rp_pkg::REG_DAC0_LVL: dac_lvl_o[0]     <= wr_lvl;
        rp_pkg::REG_DAC1_LVL: dac_lvl_o[1]     <= wr_lvl;
        rp_pkg::REG_PDM0:     pdm_lvl_o[0]     <= wr_pdm;
        rp_pkg::REG_PDM1:     pdm_lvl_o[1]     <= wr_pdm;
        rp_pkg::REG_PDM2:     pdm_lvl_o[2]     <= wr_pdm;
        rp_pkg::REG_PDM3:     pdm_lvl_o[3]     <= wr_pdm;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // signed fields sign extended, control bit and PDM levels zero extended
  always_comb begin
    rd_data = '0;
    case (reg_addr)
      rp_pkg::REG_CTRL:     rd_data = `RP_DATA_W'(digital_loop_o);
      rp_pkg::REG_ADC0_MUL: rd_data = `RP_DATA_W'(signed'(adc_cal_o[0].mul));
      rp_pkg::REG_ADC0_SUM: rd_data = `RP_DATA_W'(signed'(adc_cal_o[0].sum));
      rp_pkg::REG_ADC1_MUL: rd_data = `RP_DATA_W'(signed'(adc_cal_o[1].mul));
      rp_pkg::REG_ADC1_SUM: rd_data = `RP_DATA_W'(signed'(adc_cal_o[1].sum));
      rp_pkg::REG_DAC0_MUL: rd_data = `RP_DATA_W'(signed'(dac_cal_o[0].mul));
      rp_pkg::REG_DAC0_SUM: rd_data = `RP_DATA_W'(signed'(dac_cal_o[0].sum));
      rp_pkg::REG_DAC1_MUL: rd_data = `RP_DATA_W'(signed'(dac_cal_o[1].mul));
      rp_pkg::REG_DAC1_SUM: rd_data = `RP_DATA_W'(signed'(dac_cal_o[1].sum));
      rp_pkg::REG_DAC0_LVL: rd_data = `RP_DATA_W'(signed'(dac_lvl_o[0]));
      rp_pkg::REG_DAC1_LVL: rd_data = `RP_DATA_W'(signed'(dac_lvl_o[1]));
      rp_pkg::REG_PDM0:     rd_data = `RP_DATA_W'(pdm_lvl_o[0]);
      rp_pkg::REG_PDM1:     rd_data = `RP_DATA_W'(pdm_lvl_o[1]);
      rp_pkg::REG_PDM2:     rd_data = `RP_DATA_W'(pdm_lvl_o[2]);
      rp_pkg::REG_PDM3:     rd_data = `RP_DATA_W'(pdm_lvl_o[3]);
      // unmapped address reads as zero
      default:              rd_data = '0;
    endcase
  end

  // one cycle ack for any request
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_req_i.wen | sys_req_i.ren;
    end
  end

  // read data captured with the request, valid alongside ack
  always_ff @(posedge adc_clk) begin
    if (sys_req_i.ren) begin
      rdata_q <= rd_data;
    end
  end

  assign sys_rsp_o = '{rdata: rdata_q, ack: ack_q};

endmodule

`default_nettype wire

//--- rp_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rp_macros.svh"

module rp_top (
  input  logic                                       adc_clk,
  input  logic                                       top_rst,
  // ADC pins
  input  logic [`RP_ADC_CHN-1:0][`RP_ADC_PIN_W-1:0] adc_dat_i,
  // register bus
  input  rp_pkg::sys_req_t                           sys_req_i,
  output rp_pkg::sys_rsp_t                           sys_rsp_o,
  // calibrated ADC samples
  output rp_pkg::smp_pair_t                          adc_cal_o,
  // DAC pin words
  output rp_pkg::smp_pair_t                          dac_dat_o,
  // PDM outputs
  output logic [`RP_PDM_CHN-1:0]                     dac_pwm_o
);

  logic                           digital_loop;
  rp_pkg::cal_t [`RP_ADC_CHN-1:0] adc_cal;
  rp_pkg::cal_t [`RP_DAC_CHN-1:0] dac_cal;
  rp_pkg::smp_t [`RP_DAC_CHN-1:0] dac_lvl;
  rp_pkg::smp_t [`RP_DAC_CHN-1:0] loop_smp;
  rp_pkg::smp_t [`RP_ADC_CHN-1:0] adc_smp;
  rp_pkg::smp_t [`RP_DAC_CHN-1:0] dac_smp;
  rp_pkg::pdm_lvl_t               pdm_lvl;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  rp_regs rp_regs_i (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .sys_req_i      (sys_req_i),
    .sys_rsp_o      (sys_rsp_o),
    .digital_loop_o (digital_loop),
    .adc_cal_o      (adc_cal),
    .dac_cal_o      (dac_cal),
    .dac_lvl_o      (dac_lvl),
    .pdm_lvl_o      (pdm_lvl)
  );

  //////////////////////////////////////////////////////////////////////
  // DAC and ADC channels
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `RP_DAC_CHN; i++) begin : g_dac
    rp_dac_out rp_dac_out_i (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .lvl_i     (dac_lvl[i]),
      .cal_i     (dac_cal[i]),
      .cal_smp_o (loop_smp[i]),
      .dac_o     (dac_smp[i])
    );
  end

  // channel i loops back onto ADC channel i
  for (genvar i = 0; i < `RP_ADC_CHN; i++) begin : g_adc
    rp_adc_front rp_adc_front_i (
      .adc_clk        (adc_clk),
      .top_rst        (top_rst),
      .adc_pin_i      (adc_dat_i[i]),
      .loop_smp_i     (loop_smp[i]),
      .digital_loop_i (digital_loop),
      .cal_i          (adc_cal[i]),
      .smp_o          (adc_smp[i])
    );
  end

  // pack channel pairs
  assign adc_cal_o = '{ch1: adc_smp[1], ch0: adc_smp[0]};
  assign dac_dat_o = '{ch1: dac_smp[1], ch0: dac_smp[0]};

  //////////////////////////////////////////////////////////////////////
  // PDM
  //////////////////////////////////////////////////////////////////////

  rp_pdm rp_pdm_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .lvl_i   (pdm_lvl),
    .pdm_o   (dac_pwm_o)
  );

endmodule

`default_nettype wire

//--- rp_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rp_chk (
  input logic             adc_clk,
  input logic             top_rst,
  input rp_pkg::sys_req_t req_i,
  input rp_pkg::sys_rsp_t rsp_i
);

  ////////////////////////////////////////////////////////////////////////
  // register bus handshake
  ////////////////////////////////////////////////////////////////////////

  // ack is a single cycle pulse
  ack_pulse_a: assert property (@(posedge adc_clk) disable iff (top_rst)
    rsp_i.ack |=> !rsp_i.ack)
    else $error("ack high on two consecutive cycles");

  // every request answered on the next cycle
  ack_next_a: assert property (@(posedge adc_clk) disable iff (top_rst)
    (req_i.wen || req_i.ren) |=> rsp_i.ack)
    else $error("request not acknowledged one cycle later");

  // and never without a request
  ack_cause_a: assert property (@(posedge adc_clk) disable iff (top_rst)
    rsp_i.ack |-> $past(req_i.wen || req_i.ren))
    else $error("ack without a request one cycle earlier");

  // quiet bus in reset
  ack_rst_a: assert property (@(posedge adc_clk)
    top_rst |-> !rsp_i.ack)
    else $error("ack high during reset");

endmodule

bind rp_top rp_chk rp_chk_i (
  .adc_clk (adc_clk),
  .top_rst (top_rst),
  .req_i   (sys_req_i),
  .rsp_i   (sys_rsp_o)
);

`default_nettype wire

//--- rp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rp_macros.svh"

module rp_tb;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_ADC, OP_DAC, OP_PDM} op_e;

  // one table row
  // data holds the write value or the first ch0 pin word
  typedef struct packed {
    op_e                   op;
    rp_pkg::rp_reg_e       addr;
    logic [`RP_DATA_W-1:0] data;
    logic [`RP_DATA_W-1:0] exp;
  } step_t;

  localparam int N_STEP = 60;
  localparam step_t STEPS [N_STEP] = '{
    // reset values
    '{OP_RD,  rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_ADC0_MUL, 32'h0000_0000, 32'h0000_4000},
    '{OP_RD,  rp_pkg::REG_ADC0_SUM, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_ADC1_MUL, 32'h0000_0000, 32'h0000_4000},
    '{OP_RD,  rp_pkg::REG_ADC1_SUM, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC0_MUL, 32'h0000_0000, 32'h0000_4000},
    '{OP_RD,  rp_pkg::REG_DAC0_SUM, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC1_MUL, 32'h0000_0000, 32'h0000_4000},
    '{OP_RD,  rp_pkg::REG_DAC1_SUM, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC0_LVL, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC1_LVL, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_PDM0,     32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_PDM1,     32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_PDM2,     32'h0000_0000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_PDM3,     32'h0000_0000, 32'h0000_0000},
    // pin format at unity gain
    '{OP_ADC, rp_pkg::REG_CTRL,     32'h0000_8003, 32'h0000_0000},
    '{OP_ADC, rp_pkg::REG_CTRL,     32'h0000_7FFC, 32'h0000_0000},
    // gain near 2.0 with positive offset clips high
    '{OP_WR,  rp_pkg::REG_ADC0_MUL, 32'h0000_7FFF, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_ADC0_MUL, 32'h0000_0000, 32'h0000_7FFF},
    '{OP_WR,  rp_pkg::REG_ADC0_SUM, 32'h0000_1000, 32'h0000_0000},
    '{OP_ADC, rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    // gain -2.0 and offset -8191 clip at both ends
    '{OP_WR,  rp_pkg::REG_ADC0_MUL, 32'hFFFF_8000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_ADC0_MUL, 32'h0000_0000, 32'hFFFF_8000},
    '{OP_WR,  rp_pkg::REG_ADC0_SUM, 32'h0000_2001, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_ADC0_SUM, 32'h0000_0000, 32'hFFFF_E001},
    '{OP_ADC, rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    '{OP_ADC, rp_pkg::REG_CTRL,     32'h0000_FFFF, 32'h0000_0000},
    // half gain on ch1
    '{OP_WR,  rp_pkg::REG_ADC1_MUL, 32'h0000_2000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_ADC1_MUL, 32'h0000_0000, 32'h0000_2000},
    '{OP_WR,  rp_pkg::REG_ADC1_SUM, 32'h0000_0064, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_ADC1_SUM, 32'h0000_0000, 32'h0000_0064},
    '{OP_ADC, rp_pkg::REG_CTRL,     32'h0000_4321, 32'h0000_0000},
    // DAC words starting from the reset state
    '{OP_DAC, rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    '{OP_WR,  rp_pkg::REG_DAC0_LVL, 32'h0000_0C00, 32'h0000_0000},
    '{OP_WR,  rp_pkg::REG_DAC0_MUL, 32'h0000_6000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC0_MUL, 32'h0000_0000, 32'h0000_6000},
    '{OP_WR,  rp_pkg::REG_DAC0_SUM, 32'h0000_3F00, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC0_SUM, 32'h0000_0000, 32'hFFFF_FF00},
    '{OP_WR,  rp_pkg::REG_DAC1_LVL, 32'hABCD_3000, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC1_LVL, 32'h0000_0000, 32'hFFFF_F000},
    '{OP_WR,  rp_pkg::REG_DAC1_SUM, 32'h0000_1FFF, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC1_SUM, 32'h0000_0000, 32'h0000_1FFF},
    '{OP_DAC, rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    // loopback on and then off again
    '{OP_WR,  rp_pkg::REG_CTRL,     32'h0000_0001, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0001},
    '{OP_DAC, rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    '{OP_WR,  rp_pkg::REG_DAC0_LVL, 32'h0000_1FFF, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_DAC0_LVL, 32'h0000_0000, 32'h0000_1FFF},
    '{OP_DAC, rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    '{OP_WR,  rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000},
    '{OP_ADC, rp_pkg::REG_CTRL,     32'h0000_1234, 32'h0000_0000},
    // PDM levels
    '{OP_WR,  rp_pkg::REG_PDM0,     32'h0000_0001, 32'h0000_0000},
    '{OP_WR,  rp_pkg::REG_PDM1,     32'h0000_0080, 32'h0000_0000},
    '{OP_WR,  rp_pkg::REG_PDM2,     32'h0000_00FF, 32'h0000_0000},
    '{OP_WR,  rp_pkg::REG_PDM3,     32'h0000_0037, 32'h0000_0000},
    '{OP_RD,  rp_pkg::REG_PDM0,     32'h0000_0000, 32'h0000_0001},
    '{OP_RD,  rp_pkg::REG_PDM1,     32'h0000_0000, 32'h0000_0080},
    '{OP_RD,  rp_pkg::REG_PDM2,     32'h0000_0000, 32'h0000_00FF},
    '{OP_RD,  rp_pkg::REG_PDM3,     32'h0000_0000, 32'h0000_0037},
    '{OP_PDM, rp_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0000}
  };

  logic                                       adc_clk;
  logic                                       top_rst;
  logic [`RP_ADC_CHN-1:0][`RP_ADC_PIN_W-1:0] adc_dat_i;
  rp_pkg::sys_req_t                           sys_req_i;
  rp_pkg::sys_rsp_t                           sys_rsp_o;
  rp_pkg::smp_pair_t                          adc_cal_o;
  rp_pkg::smp_pair_t                          dac_dat_o;
  logic [`RP_PDM_CHN-1:0]                     dac_pwm_o;

  // expected register contents
  rp_pkg::cal_t         adc_cal_ref [`RP_ADC_CHN];
  rp_pkg::cal_t         dac_cal_ref [`RP_DAC_CHN];
  rp_pkg::smp_t         lvl_ref [`RP_DAC_CHN];
  logic [`RP_PDM_W-1:0] pdm_ref [`RP_PDM_CHN];
  logic                 loop_ref;

  rp_top rp_top_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .adc_cal_o (adc_cal_o),
    .dac_dat_o (dac_dat_o),
    .dac_pwm_o (dac_pwm_o)
  );

  // 100 ns period
  always #50 adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  // gain in Q14 with floor shift, then offset and clip to 14 bits
  function automatic rp_pkg::smp_t lin_ref(rp_pkg::smp_t x, rp_pkg::cal_t c);
    longint v;
    v = (longint'(x) * longint'($signed(c.mul))) >>> `RP_MUL_FRAC;
    v = v + longint'($signed(c.sum));
    if (v > 8191) begin
      v = 8191;
    end else if (v < -8192) begin
      v = -8192;
    end
    return rp_pkg::smp_t'(v);
  endfunction

  // sign kept and bits 14..2 inverted
  function automatic rp_pkg::smp_t pin_ref(logic [`RP_ADC_PIN_W-1:0] w);
    return {w[15], ~w[14:2]};
  endfunction

  // inverted offset binary
  function automatic rp_pkg::smp_t dac_ref(rp_pkg::smp_t s);
    return {s[13], ~s[12:0]};
  endfunction

  // address bits pick field and channel
  task automatic update_ref(input rp_pkg::rp_reg_e addr, input logic [`RP_DATA_W-1:0] d);
    case (addr[7:4])
      4'h0: loop_ref = d[0];
      4'h1: begin
        if (addr[2]) begin
          adc_cal_ref[addr[3]].sum = d[13:0];
        end else begin
          adc_cal_ref[addr[3]].mul = d[15:0];
        end
      end
      4'h2: begin
        if (addr[2]) begin
          dac_cal_ref[addr[3]].sum = d[13:0];
        end else begin
          dac_cal_ref[addr[3]].mul = d[15:0];
        end
      end
      4'h3: lvl_ref[addr[2]] = d[13:0];
      4'h4: pdm_ref[addr[3:2]] = d[7:0];
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_smp(input string name, input rp_pkg::smp_t got, input rp_pkg::smp_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [`RP_DATA_W-1:0] got,
                            input logic [`RP_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s count got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_ack(input logic [`RP_ADDR_W-1:0] addr);
    int n;
    n = 0;
    while (!sys_rsp_o.ack && n < 20) begin
      @(posedge adc_clk);
      #1;
      n++;
    end
    if (!sys_rsp_o.ack) begin
      $display("bus request to address 0x%h got no ack within 20 cycles", addr);
      abort_run();
    end
  endtask

  task automatic bus_write(input logic [`RP_ADDR_W-1:0] addr, input logic [`RP_DATA_W-1:0] d);
    sys_req_i.wen   = 1'b1;
    sys_req_i.addr  = addr;
    sys_req_i.wdata = d;
    @(posedge adc_clk);
    #1;
    sys_req_i.wen = 1'b0;
    wait_ack(addr);
    // idle cycle so ack drops between requests
    @(posedge adc_clk);
    #1;
  endtask

  task automatic bus_read(input logic [`RP_ADDR_W-1:0] addr, output logic [`RP_DATA_W-1:0] d);
    sys_req_i.ren  = 1'b1;
    sys_req_i.addr = addr;
    @(posedge adc_clk);
    #1;
    sys_req_i.ren = 1'b0;
    wait_ack(addr);
    d = sys_rsp_o.rdata;
    @(posedge adc_clk);
    #1;
  endtask

  task automatic drive_pins(input logic [`RP_ADC_PIN_W-1:0] w0);
    adc_dat_i[0] = w0;
    adc_dat_i[1] = 16'($urandom());
  endtask

  // new pin words every cycle and each checked 3 cycles later
  task automatic adc_stream(input logic [`RP_ADC_PIN_W-1:0] first);
    rp_pkg::smp_t exp0 [$];
    rp_pkg::smp_t exp1 [$];
    for (int k = 0; k < 11; k++) begin
      if (k >= 3) begin
        check_smp("adc_cal_o.ch0", adc_cal_o.ch0, exp0.pop_front());
        check_smp("adc_cal_o.ch1", adc_cal_o.ch1, exp1.pop_front());
      end
      if (k < 8) begin
        drive_pins(k == 0 ? first : 16'($urandom()));
        exp0.push_back(lin_ref(pin_ref(adc_dat_i[0]), adc_cal_ref[0]));
        exp1.push_back(lin_ref(pin_ref(adc_dat_i[1]), adc_cal_ref[1]));
      end
      @(posedge adc_clk);
      #1;
    end
  endtask

  // 3 cycles of DAC latency plus margin
  // pins keep moving meanwhile
  task automatic dac_settle();
    rp_pkg::smp_t cal0;
    rp_pkg::smp_t cal1;
    repeat (5) begin
      drive_pins(16'($urandom()));
      @(posedge adc_clk);
      #1;
    end
    cal0 = lin_ref(lvl_ref[0], dac_cal_ref[0]);
    cal1 = lin_ref(lvl_ref[1], dac_cal_ref[1]);
    check_smp("dac_dat_o.ch0", dac_dat_o.ch0, dac_ref(cal0));
    check_smp("dac_dat_o.ch1", dac_dat_o.ch1, dac_ref(cal1));
    // loopback ignores the pins
    if (loop_ref) begin
      check_smp("adc_cal_o.ch0", adc_cal_o.ch0, lin_ref(cal0, adc_cal_ref[0]));
      check_smp("adc_cal_o.ch1", adc_cal_o.ch1, lin_ref(cal1, adc_cal_ref[1]));
    end
  endtask

  task automatic pdm_window();
    int cnt [`RP_PDM_CHN];
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      cnt[i] = 0;
    end
    @(posedge adc_clk);
    #1;
    repeat (256) begin
      @(posedge adc_clk);
      #1;
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        if (dac_pwm_o[i]) begin
          cnt[i]++;
        end
      end
    end
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      check_count($sformatf("dac_pwm_o[%0d]", i), cnt[i], int'(pdm_ref[i]));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [`RP_DATA_W-1:0] rd;
    adc_clk   = 1'b0;
    top_rst   = 1'b1;
    adc_dat_i = '0;
    sys_req_i = '0;
    loop_ref  = 1'b0;
    for (int i = 0; i < `RP_DAC_CHN; i++) begin
      adc_cal_ref[i] = '{mul: `RP_MUL_ONE, sum: 0};
      dac_cal_ref[i] = '{mul: `RP_MUL_ONE, sum: 0};
      lvl_ref[i]     = '0;
    end
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      pdm_ref[i] = '0;
    end
    void'($urandom(34497));
    repeat (3) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;
    // unmapped address
    bus_read(8'h08, rd);
    check_word("rdata at 0x08", rd, '0);
    for (int s = 0; s < N_STEP; s++) begin
      case (STEPS[s].op)
        OP_WR: begin
          bus_write(STEPS[s].addr, STEPS[s].data);
          update_ref(STEPS[s].addr, STEPS[s].data);
        end
        OP_RD: begin
          bus_read(STEPS[s].addr, rd);
          check_word($sformatf("rdata at 0x%h", STEPS[s].addr), rd, STEPS[s].exp);
        end
        OP_ADC: adc_stream(STEPS[s].data[15:0]);
        OP_DAC: dac_settle();
        OP_PDM: pdm_window();
        default: ;
      endcase
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
rp_pkg.sv
rp_linear.sv
rp_adc_front.sv
rp_dac_out.sv
rp_pdm.sv
rp_regs.sv
rp_top.sv
rp_chk.sv
rp_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, then search the log
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rp_tb \
  -f sources.f -o rp_sim > "$LOG" 2>&1 \
  && ./obj_dir/rp_sim >> "$LOG" 2>&1 \
  || echo "TESTBENCH FAILED" >> "$LOG"

cat "$LOG"
if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0
